/* common/rv_pkg.sv */
package rv_pkg;

  // data path and register address widths
  localparam int XLEN   = 32;
  localparam int REG_AW = 4;
  localparam int SHAMT_W = $clog2(XLEN);

  // opcodes accepted by the slice
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG   = 7'b0110011;

  // encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  function automatic logic [XLEN-1:0] alu_calc(
    input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b,
    input alu_op_e         op
  );
    logic [SHAMT_W-1:0] shamt;
    shamt = b[SHAMT_W-1:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << shamt;
      ALU_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: return {{(XLEN-1){1'b0}}, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> shamt;
      ALU_SRA:  return $signed(a) >>> shamt;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      // encodings outside the table behave as add
      default:  return a + b;
    endcase
  endfunction

endpackage

/* common/dec_if.sv */
interface dec_if #(
  parameter int W = rv_pkg::XLEN
);
  import rv_pkg::*;

  logic              valid;
  logic              ready;
  logic [W-1:0]      op1;
  logic [W-1:0]      op2;
  alu_op_e           alu_op;
  logic [REG_AW-1:0] rd;
  logic              illegal;

  // decode side
  modport src (
    output valid, op1, op2, alu_op, rd, illegal,
    input  ready
  );

  // execute side
  modport dst (
    input  valid, op1, op2, alu_op, rd, illegal,
    output ready
  );

endinterface

/* hdl/inst_queue.sv */
module inst_queue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic [31:0]             inst_i,
  input  logic [rv_pkg::XLEN-1:0] pc_i,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic [31:0]             out_inst_o,
  output logic [rv_pkg::XLEN-1:0] out_pc_o
);
  import rv_pkg::*;

  logic [31:0]     inst_mem [2];
  logic [XLEN-1:0] pc_mem   [2];
  logic            rd_ptr;
  logic            wr_ptr;
  logic [1:0]      count;
  logic            push;
  logic            pop;

  // full only when both slots hold a pair
  assign in_ready_o  = (count != 2'd2);
  assign out_valid_o = (count != 2'd0);
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  assign out_inst_o = inst_mem[rd_ptr];
  assign out_pc_o   = pc_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= 1'b0;
      wr_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // push and pop together leave the count as is
      if (push && !pop) begin
        count <= count + 2'd1;
      end else if (pop && !push) begin
        count <= count - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      inst_mem[wr_ptr] <= inst_i;
      pc_mem[wr_ptr]   <= pc_i;
    end
  end

endmodule

/* decode/idu_stage.sv */
module idu_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic [31:0]               inst_i,
  input  logic [rv_pkg::XLEN-1:0]   pc_i,
  output logic [rv_pkg::REG_AW-1:0] rs1_o,
  output logic [rv_pkg::REG_AW-1:0] rs2_o,
  input  logic [rv_pkg::XLEN-1:0]   rdata1_i,
  input  logic [rv_pkg::XLEN-1:0]   rdata2_i,
  input  logic                      fwd_valid_i,
  input  logic [rv_pkg::REG_AW-1:0] fwd_rd_i,
  input  logic [rv_pkg::XLEN-1:0]   fwd_data_i,
  dec_if.src                        dec
);
  import rv_pkg::*;

  logic              valid_q;
  logic [31:0]       inst_q;
  logic [XLEN-1:0]   pc_q;
  logic              load;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_u;
  logic [XLEN-1:0]   src1;
  logic [XLEN-1:0]   src2;
  logic [XLEN-1:0]   op1;
  logic [XLEN-1:0]   op2;
  alu_op_e           alu_op;
  logic              illegal;

  // accept when empty or when the held beat moves on this cycle
  assign in_ready_o = !valid_q || dec.ready;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // RV32E fields, upper register address bit ignored
  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign rd     = inst_q[7 +: REG_AW];
  assign rs1    = inst_q[15 +: REG_AW];
  assign rs2    = inst_q[20 +: REG_AW];
  assign rs1_o  = rs1;
  assign rs2_o  = rs2;

  assign imm_i = XLEN'($signed(inst_q[31:20]));
  assign imm_u = {inst_q[31:12], 12'b0};

  // execute result overrides the register file until it is written back
  assign src1 = (fwd_valid_i && fwd_rd_i == rs1 && rs1 != '0) ? fwd_data_i : rdata1_i;
  assign src2 = (fwd_valid_i && fwd_rd_i == rs2 && rs2 != '0) ? fwd_data_i : rdata2_i;

  always_comb begin
    op1     = '0;
    op2     = '0;
    alu_op  = ALU_ADD;
    illegal = 1'b0;
    case (opcode)
      OP_LUI: begin
        op2 = imm_u;
      end
      OP_AUIPC: begin
        op1 = pc_q;
        op2 = imm_u;
      end
      OP_IMM: begin
        op1 = src1;
        op2 = imm_i;
        // funct7 bit only meaningful for srai
        alu_op = alu_op_e'({(funct3 == 3'b101) && funct7[5], funct3});
      end
      OP_REG: begin
        op1    = src1;
        op2    = src2;
        alu_op = alu_op_e'({funct7[5], funct3});
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  assign dec.valid   = valid_q;
  assign dec.op1     = op1;
  assign dec.op2     = op2;
  assign dec.alu_op  = alu_op;
  assign dec.rd      = rd;
  assign dec.illegal = illegal;

endmodule

/* hdl/reg_file.sv */
module reg_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [rv_pkg::REG_AW-1:0] raddr1_i,
  input  logic [rv_pkg::REG_AW-1:0] raddr2_i,
  output logic [rv_pkg::XLEN-1:0]   rdata1_o,
  output logic [rv_pkg::XLEN-1:0]   rdata2_o,
  input  logic                      we_i,
  input  logic [rv_pkg::REG_AW-1:0] waddr_i,
  input  logic [rv_pkg::XLEN-1:0]   wdata_i
);
  import rv_pkg::*;

  localparam int NREGS = 2 ** REG_AW;

  logic [XLEN-1:0] regs [NREGS];

  // x0 reads as zero whatever is stored
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

/* hdl/exu_stage.sv */
module exu_stage #(
  parameter int XLEN_P = rv_pkg::XLEN
) (
  input  logic                      clk,
  input  logic                      rst,
  dec_if.dst                        dec,
  output logic                      wb_valid_o,
  input  logic                      wb_ready_i,
  output logic [rv_pkg::REG_AW-1:0] wb_rd_o,
  output logic [XLEN_P-1:0]         wb_data_o,
  output logic                      wb_illegal_o,
  output logic                      fwd_valid_o,
  output logic [rv_pkg::REG_AW-1:0] fwd_rd_o,
  output logic [rv_pkg::XLEN-1:0]   fwd_data_o,
  output logic                      rf_we_o,
  output logic [rv_pkg::REG_AW-1:0] rf_waddr_o,
  output logic [rv_pkg::XLEN-1:0]   rf_wdata_o
);
  import rv_pkg::*;

  logic              valid_q;
  logic [REG_AW-1:0] rd_q;
  logic [XLEN_P-1:0] data_q;
  logic              illegal_q;
  logic              leave;
  logic              take;
  logic              signed_ops;
  logic [XLEN_P-1:0] op1_n;
  logic [XLEN_P-1:0] op2_n;
  logic [XLEN-1:0]   op1_x;
  logic [XLEN-1:0]   op2_x;
  logic [XLEN-1:0]   alu_res;

  assign leave     = valid_q && wb_ready_i;
  assign dec.ready = !valid_q || wb_ready_i;
  assign take      = dec.valid && dec.ready;

  // operands cut to execute width, then widened so signed ops keep their meaning
  assign op1_n      = dec.op1[XLEN_P-1:0];
  assign op2_n      = dec.op2[XLEN_P-1:0];
  assign signed_ops = (dec.alu_op == ALU_SLT) || (dec.alu_op == ALU_SRA);
  assign op1_x      = signed_ops ? XLEN'($signed(op1_n)) : XLEN'(op1_n);
  assign op2_x      = signed_ops ? XLEN'($signed(op2_n)) : XLEN'(op2_n);
  assign alu_res    = alu_calc(op1_x, op2_x, dec.alu_op);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (dec.ready) begin
      valid_q <= dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rd_q      <= dec.rd;
      illegal_q <= dec.illegal;
      // illegal beats report zero
      data_q    <= dec.illegal ? '0 : alu_res[XLEN_P-1:0];
    end
  end

  assign wb_valid_o   = valid_q;
  assign wb_rd_o      = rd_q;
  assign wb_data_o    = data_q;
  assign wb_illegal_o = illegal_q;

  // illegal beats forward as x0 so no source ever matches them
  assign fwd_valid_o = valid_q;
  assign fwd_rd_o    = illegal_q ? '0 : rd_q;
  assign fwd_data_o  = XLEN'(data_q);

  // commit to the register file as the beat leaves
  assign rf_we_o    = leave && !illegal_q && (rd_q != '0);
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = XLEN'(data_q);

endmodule

/* hdl/rv_slice_top.sv */
module rv_slice_top #(
  parameter int XLEN_P = rv_pkg::XLEN
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic [31:0]               inst_i,
  input  logic [rv_pkg::XLEN-1:0]   pc_i,
  output logic                      wb_valid_o,
  input  logic                      wb_ready_i,
  output logic [rv_pkg::REG_AW-1:0] wb_rd_o,
  output logic [XLEN_P-1:0]         wb_data_o,
  output logic                      wb_illegal_o
);
  import rv_pkg::*;

  // queue to decode
  logic              q_valid;
  logic              q_ready;
  logic [31:0]       q_inst;
  logic [XLEN-1:0]   q_pc;
  // register file reads
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [XLEN-1:0]   rdata1;
  logic [XLEN-1:0]   rdata2;
  // execute back to decode and register file
  logic              fwd_valid;
  logic [REG_AW-1:0] fwd_rd;
  logic [XLEN-1:0]   fwd_data;
  logic              rf_we;
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;

  dec_if #(.W(XLEN)) dec_bus ();

  inst_queue u_queue (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .out_valid_o (q_valid),
    .out_ready_i (q_ready),
    .out_inst_o  (q_inst),
    .out_pc_o    (q_pc)
  );

  idu_stage u_idu (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (q_valid),
    .in_ready_o  (q_ready),
    .inst_i      (q_inst),
    .pc_i        (q_pc),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .fwd_valid_i (fwd_valid),
    .fwd_rd_i    (fwd_rd),
    .fwd_data_i  (fwd_data),
    .dec         (dec_bus.src)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  exu_stage #(.XLEN_P(XLEN_P)) u_exu (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec_bus.dst),
    .wb_valid_o   (wb_valid_o),
    .wb_ready_i   (wb_ready_i),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o),
    .wb_illegal_o (wb_illegal_o),
    .fwd_valid_o  (fwd_valid),
    .fwd_rd_o     (fwd_rd),
    .fwd_data_o   (fwd_data),
    .rf_we_o      (rf_we),
    .rf_waddr_o   (rf_waddr),
    .rf_wdata_o   (rf_wdata)
  );

endmodule

/* dv/rv_slice_tb.sv */
module rv_slice_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NREC           = 22;
  localparam int NFIELD         = 5;
  localparam int TIMEOUT_CYCLES = 8 * NREC + 50;

  typedef struct {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [3:0]  rd;
    logic [31:0] result;
    logic        illegal;
  } rec_t;

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic        in_ready_o;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        wb_valid_o;
  logic        wb_ready_i;
  logic [3:0]  wb_rd_o;
  logic [31:0] wb_data_o;
  logic        wb_illegal_o;

  logic [31:0] raw [NREC*NFIELD];
  rec_t        recs [NREC];
  // record indices in the order the queue accepted them
  int          exp_q [$];
  int          errors   = 0;
  int          wb_count = 0;
  int          cycles   = 0;
  integer      seed     = 32'h32a6_8611;

  rv_slice_top UUT (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .wb_valid_o   (wb_valid_o),
    .wb_ready_i   (wb_ready_i),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o),
    .wb_illegal_o (wb_illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      errors++;
    end
  endtask

  task automatic load_records();
    $readmemh("dv/rv_slice_testdata.mem", raw);
    for (int i = 0; i < NREC; i++) begin
      recs[i].inst    = raw[i*NFIELD];
      recs[i].pc      = raw[i*NFIELD+1];
      recs[i].rd      = raw[i*NFIELD+2][3:0];
      recs[i].result  = raw[i*NFIELD+3];
      recs[i].illegal = raw[i*NFIELD+4][0];
    end
    if ($isunknown(raw[0])) begin
      $display("test data file dv/rv_slice_testdata.mem could not be read");
      errors++;
    end
  endtask

  task automatic send_inst(input int idx);
    in_valid_i = 1'b1;
    inst_i     = recs[idx].inst;
    pc_i       = recs[idx].pc;
    // the pair is taken at the first edge that sees ready high
    @(posedge clk);
    while (!in_ready_o) begin
      @(posedge clk);
    end
    exp_q.push_back(idx);
    #1;
  endtask

  task automatic check_beat();
    int idx;
    wb_count++;
    if (exp_q.size() == 0) begin
      $display("unexpected writeback at %0t with no instruction outstanding", $time);
      errors++;
    end else begin
      idx = exp_q.pop_front();
      check_value(32'(wb_rd_o), 32'(recs[idx].rd), $sformatf("record %0d rd", idx));
      check_value(wb_data_o, recs[idx].result, $sformatf("record %0d result", idx));
      check_value(32'(wb_illegal_o), 32'(recs[idx].illegal),
                  $sformatf("record %0d illegal flag", idx));
    end
  endtask

  task automatic report_and_finish();
    $display("errors %0d, writebacks %0d of %0d", errors, wb_count, NREC);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // random back-pressure with ready high about three cycles in four
  initial begin : ready_driver
    wb_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      wb_ready_i = (($random(seed) & 3) != 0);
    end
  end

  always @(posedge clk) begin
    if (!rst && wb_valid_o && wb_ready_i) begin
      check_beat();
    end
  end

  initial begin : watchdog
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: writebacks missing");
    errors++;
    report_and_finish();
  end

  initial begin : main
    rst        = 1'b1;
    in_valid_i = 1'b0;
    inst_i     = '0;
    pc_i       = '0;
    load_records();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < NREC; i++) begin
      send_inst(i);
    end
    in_valid_i = 1'b0;
    while (wb_count < NREC) begin
      @(posedge clk);
    end
    // a few idle cycles catch any duplicated beat
    repeat (4) @(posedge clk);
    check_value(32'(wb_count), 32'(NREC), "writeback count");
    report_and_finish();
  end

endmodule

/* dv/rv_slice_testdata.mem */
// columns: instruction pc expected_rd expected_result expected_illegal, all hex
// registers start at zero, records run in order
123450b7 00000100 1 12345000 0 // lui   x1, 0x12345
00001117 00000104 2 00001104 0 // auipc x2, 0x1
67808193 00000108 3 12345678 0 // addi  x3, x1, 0x678
fff18213 0000010c 4 12345677 0 // addi  x4, x3, -1
401202b3 00000110 5 00000677 0 // sub   x5, x4, x1
00429313 00000114 6 00006770 0 // slli  x6, x5, 4
800003b7 00000118 7 80000000 0 // lui   x7, 0x80000
4043d413 0000011c 8 f8000000 0 // srai  x8, x7, 4
0043d493 00000120 9 08000000 0 // srli  x9, x7, 4
4053d533 00000124 a ffffff00 0 // sra   x10, x7, x5
0053d5b3 00000128 b 00000100 0 // srl   x11, x7, x5
00942633 0000012c c 00000001 0 // slt   x12, x8, x9
009436b3 00000130 d 00000000 0 // sltu  x13, x8, x9
0091c733 00000134 e 1a345678 0 // xor   x14, x3, x9
006767b3 00000138 f 1a347778 0 // or    x15, x14, x6
0f07f093 0000013c 1 00000070 0 // andi  x1, x15, 0xf0
00508013 00000140 0 00000075 0 // addi  x0, x1, 5
00100133 00000144 2 00000070 0 // add   x2, x0, x1
0000a183 00000148 3 00000000 1 // lw opcode, illegal here
00018213 0000014c 4 12345678 0 // addi  x4, x3, 0
404002b3 00000150 5 edcba988 0 // sub   x5, x0, x4
0002a313 00000154 6 00000001 0 // slti  x6, x5, 0

/* rv_slice.f */
common/rv_pkg.sv
common/dec_if.sv
hdl/inst_queue.sv
decode/idu_stage.sv
hdl/reg_file.sv
hdl/exu_stage.sv
hdl/rv_slice_top.sv
dv/rv_slice_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the slice testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
set -o pipefail
LOG=sim.log

verilator --binary --timing -sv --timescale 1ns/100ps \
  --top-module rv_slice_tb -f rv_slice.f -Mdir obj_dir \
  && ./obj_dir/Vrv_slice_tb 2>&1 | tee "$LOG" \
  || { echo "build or simulation error"; exit 1; }

grep -q "Simulation failed" "$LOG" \
  && { echo "FAIL"; exit 1; } \
  || { echo "PASS"; exit 0; }
